// File: src/soc_bus_pkg.sv
//############################
// Bus widths, opcodes and decoder states shared by the
// bus decoder and every peripheral hanging off it
//############################
package soc_bus_pkg;

	localparam int DATA_W = 32;

	// Word addressed, the byte offset bits never reach the bus
	localparam int ADDR_W = DATA_W - $clog2(DATA_W / 8);

	localparam int SEL_W = DATA_W / 8;

	// Two-bit op field driven by the bus master
	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} bus_op_e;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_ACCESS = 2'd1,
		ST_DONE   = 2'd2
	} dec_state_e;

	// Edges from a sampled request to the edge that sees its ready
	localparam int BUS_LATENCY = 2;

endpackage

// File: src/soc_devmap_pkg.sv
//############################
// Slave map of the controller: indices, ids, map sizes,
// base addresses and the device table word layout
//############################
package soc_devmap_pkg;

	typedef enum logic [1:0] {
		SL_DEVTBL  = 2'd0,
		SL_GP0     = 2'd1,
		SL_GP1     = 2'd2,
		SL_INVALID = 2'd3
	} slave_e;

	localparam int SLAVE_COUNT = 4;

	localparam logic [31:0] DEV_ID [SLAVE_COUNT] = '{32'd7, 32'd6, 32'd6, 32'd0};
	// Sizes in words, the default slave takes no space
	localparam logic [31:0] DEV_MAPSZ [SLAVE_COUNT] = '{32'd16, 32'd4, 32'd4, 32'd0};
	localparam logic [SLAVE_COUNT-1:0] DEV_USEINTR = 4'b0110;

	// Slaves are packed back to back from word zero
	function automatic logic [soc_bus_pkg::ADDR_W-1:0] base_of(input int idx);
		logic [31:0] sum;
		sum = '0;
		for (int k = 0; k < idx; k++) begin
			sum = sum + DEV_MAPSZ[k];
		end
		return sum[soc_bus_pkg::ADDR_W-1:0];
	endfunction

	localparam logic [soc_bus_pkg::ADDR_W-1:0] DEV_BASE [SLAVE_COUNT] =
		'{base_of(0), base_of(1), base_of(2), base_of(3)};

	// Device table layout
	localparam int DT_ADDR_W = 4;
	localparam int DT_USEINTR_BIT = 31;
	localparam logic [DT_ADDR_W-1:0] DT_RST_WORD = 4'd15;
	localparam logic [31:0] SOC_ID = 32'd2;

endpackage

// File: src/reset_seq.sv
//############################
// Power-on countdown and software reset decode, driving
// the synchronous system reset of the whole block
//############################
`timescale 1ns/1ps

module reset_seq #(
	parameter int RST_CNT_BITS = 16
) (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic sw_rst0_i,
	input  logic sw_rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNT_BITS-1:0] rst_cnt;
	logic pwr_off_q;
	logic sw_cold;
	logic sw_warm;
	logic sw_pwr_off;

	assign sw_cold    = sw_rst0_i & sw_rst1_i;
	assign sw_warm    = ~sw_rst0_i & sw_rst1_i;
	assign sw_pwr_off = sw_rst0_i & ~sw_rst1_i;

	// No global reset primitive, so cold reset also just restarts the count
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || sw_cold || sw_warm) begin
			rst_cnt <= '1;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	// Power-off parks the system in reset until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (sw_pwr_off) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cnt != '0) || pwr_off_q;

	// Device table sits in reset too, so nothing may restart a running countdown
	a_countdown: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		$past(sys_rst_o) && !$past(rst_p) && (rst_cnt != '0) |-> rst_cnt < $past(rst_cnt))
		else $error("reset countdown restarted while the system was held in reset");

endmodule

// File: src/bus_decoder.sv
//############################
// Bus control: latches one request, strobes the slave that
// owns the address and returns read data with a ready strobe
//############################
`timescale 1ns/1ps

module bus_decoder (
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  soc_bus_pkg::bus_op_e bus_op_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] bus_wdata_i,
	input  logic [soc_bus_pkg::SEL_W-1:0] bus_sel_i,
	output logic [soc_bus_pkg::DATA_W-1:0] bus_rdata_o,
	output logic bus_rdy_o,
	output soc_bus_pkg::bus_op_e slv_op_o,
	output logic [soc_bus_pkg::ADDR_W-1:0] slv_addr_o,
	output logic [soc_bus_pkg::DATA_W-1:0] slv_wdata_o,
	output logic [soc_bus_pkg::SEL_W-1:0] slv_sel_o,
	output logic [soc_devmap_pkg::SLAVE_COUNT-1:0] slv_stb_o,
	input  logic [soc_bus_pkg::DATA_W-1:0] dt_rdata_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] gp0_rdata_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] gp1_rdata_i
);
	import soc_bus_pkg::*;
	import soc_devmap_pkg::*;

	dec_state_e state;
	bus_op_e op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [SEL_W-1:0] sel_q;
	slave_e slv_q;
	slave_e slv_hit;
	logic [DATA_W-1:0] slv_rdata;

	// Maps never overlap; anything outside them lands on the default slave
	always_comb begin
		slv_hit = SL_INVALID;
		for (int k = 0; k < SLAVE_COUNT; k++) begin
			if ((bus_addr_i >= DEV_BASE[k]) &&
				((bus_addr_i - DEV_BASE[k]) < DEV_MAPSZ[k][ADDR_W-1:0])) begin
				slv_hit = slave_e'(k[1:0]);
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (bus_op_i != OP_NOP)
						state <= ST_ACCESS;
				end
				ST_ACCESS: state <= ST_DONE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (state == ST_IDLE) begin
			op_q    <= bus_op_i;
			addr_q  <= bus_addr_i;
			wdata_q <= bus_wdata_i;
			sel_q   <= bus_sel_i;
			slv_q   <= slv_hit;
		end
	end

	always_comb begin
		case (slv_q)
			SL_DEVTBL: slv_rdata = dt_rdata_i;
			SL_GP0:    slv_rdata = gp0_rdata_i;
			SL_GP1:    slv_rdata = gp1_rdata_i;
			default:   slv_rdata = '0;
		endcase
	end

	// Writes return zero data
	always_ff @(posedge clk_2x_w) begin
		if (state == ST_ACCESS)
			bus_rdata_o <= (op_q == OP_READ) ? slv_rdata : '0;
	end

	always_comb begin
		slv_stb_o = '0;
		if (state == ST_ACCESS)
			slv_stb_o[slv_q] = 1'b1;
	end

	assign slv_op_o    = op_q;
	assign slv_addr_o  = addr_q - DEV_BASE[slv_q];
	assign slv_wdata_o = wdata_q;
	assign slv_sel_o   = sel_q;
	assign bus_rdy_o   = (state == ST_DONE);

	a_rdy_single: assert property (@(posedge clk_2x_w) disable iff (sys_rst_i)
		bus_rdy_o |=> !bus_rdy_o);
	a_stb_onehot: assert property (@(posedge clk_2x_w) $onehot0(slv_stb_o));

endmodule

// File: src/dev_table.sv
//############################
// Read-only device description words plus the software
// reset register that feeds the reset sequencer
//############################
`timescale 1ns/1ps

module dev_table (
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  logic stb_i,
	input  soc_bus_pkg::bus_op_e op_i,
	input  logic [soc_devmap_pkg::DT_ADDR_W-1:0] addr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] wdata_i,
	output logic [soc_bus_pkg::DATA_W-1:0] rdata_o,
	output logic sw_rst0_o,
	output logic sw_rst1_o
);
	import soc_bus_pkg::*;
	import soc_devmap_pkg::*;

	localparam int IDX_W = $clog2(SLAVE_COUNT);

	logic [IDX_W-1:0] dev_idx;
	logic rst_wr;

	// Two words per slave: id with the interrupt flag on top, then map size
	assign dev_idx = addr_i[IDX_W:1];

	always_comb begin
		rdata_o = '0;
		if (addr_i == DT_RST_WORD) begin
			rdata_o = SOC_ID;
		end else if (addr_i[DT_ADDR_W-1:IDX_W+1] == '0) begin
			if (addr_i[0]) begin
				rdata_o = DEV_MAPSZ[dev_idx];
			end else begin
				rdata_o = DEV_ID[dev_idx];
				rdata_o[DT_USEINTR_BIT] = DEV_USEINTR[dev_idx];
			end
		end
	end

	assign rst_wr = stb_i && (op_i == OP_WRITE) && (addr_i == DT_RST_WORD);

	// One-cycle pulses, lined up with the ready of the write
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			sw_rst0_o <= 1'b0;
			sw_rst1_o <= 1'b0;
		end else begin
			sw_rst0_o <= rst_wr & wdata_i[0];
			sw_rst1_o <= rst_wr & wdata_i[1];
		end
	end

endmodule

// File: src/gpio_port.sv
//############################
// One GPIO port: synced inputs, output register and
// write-one-to-clear change flags raising an interrupt
//############################
`timescale 1ns/1ps

module gpio_port #(
	parameter int IO_COUNT = 16
) (
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  logic stb_i,
	input  soc_bus_pkg::bus_op_e op_i,
	input  logic [1:0] addr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] wdata_i,
	input  logic [soc_bus_pkg::SEL_W-1:0] sel_i,
	output logic [soc_bus_pkg::DATA_W-1:0] rdata_o,
	input  logic [IO_COUNT-1:0] pins_i,
	output logic [IO_COUNT-1:0] pins_o,
	output logic irq_o
);
	import soc_bus_pkg::*;

	localparam logic [1:0] GPIO_IN_WORD  = 2'd0;
	localparam logic [1:0] GPIO_OUT_WORD = 2'd1;
	localparam logic [1:0] GPIO_CHG_WORD = 2'd2;

	logic [IO_COUNT-1:0] sync1;
	logic [IO_COUNT-1:0] sync2;
	logic [IO_COUNT-1:0] prev;
	logic [IO_COUNT-1:0] chg;
	logic [IO_COUNT-1:0] clr;
	logic [DATA_W-1:0] wmask;
	logic wr;

	always_comb begin
		for (int b = 0; b < SEL_W; b++) begin
			wmask[b*8 +: 8] = {8{sel_i[b]}};
		end
	end

	assign wr  = stb_i && (op_i == OP_WRITE);
	assign clr = (wr && (addr_i == GPIO_CHG_WORD)) ?
		(wdata_i[IO_COUNT-1:0] & wmask[IO_COUNT-1:0]) : '0;

	// Two stages against metastability, then the edge compare
	always_ff @(posedge clk_2x_w) begin
		sync1 <= pins_i;
		sync2 <= sync1;
		prev  <= sync2;
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			pins_o <= '0;
			chg    <= '0;
		end else begin
			if (wr && (addr_i == GPIO_OUT_WORD))
				pins_o <= (pins_o & ~wmask[IO_COUNT-1:0]) |
					(wdata_i[IO_COUNT-1:0] & wmask[IO_COUNT-1:0]);
			// a change in the clearing cycle stays flagged
			chg <= (chg & ~clr) | (sync2 ^ prev);
		end
	end

	always_comb begin
		rdata_o = '0;
		case (addr_i)
			GPIO_IN_WORD:  rdata_o[IO_COUNT-1:0] = sync2;
			GPIO_OUT_WORD: rdata_o[IO_COUNT-1:0] = pins_o;
			GPIO_CHG_WORD: rdata_o[IO_COUNT-1:0] = chg;
			default:       rdata_o = '0;
		endcase
	end

	assign irq_o = |chg;

endmodule

// File: src/activity_led.sv
//############################
// Activity LED pulse, dimmed by a holdoff counter
//############################
`timescale 1ns/1ps

module activity_led #(
	parameter int ACT_CNT_BITS = 7
) (
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  logic trig_i,
	output logic activity_o
);

	logic [ACT_CNT_BITS-1:0] hold_cnt;

	// Triggers during the holdoff are dropped, which keeps the LED dim
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			hold_cnt   <= '0;
			activity_o <= 1'b0;
		end else if (hold_cnt != '0) begin
			hold_cnt   <= hold_cnt - 1'b1;
			activity_o <= 1'b0;
		end else begin
			hold_cnt   <= {ACT_CNT_BITS{trig_i}};
			activity_o <= trig_i;
		end
	end

endmodule

// File: src/soc_ctrl_top.sv
//############################
// System controller top: bus decoder, device table, reset
// sequencer, two GPIO ports and the activity LED
//############################
`timescale 1ns/1ps

module soc_ctrl_top #(
	parameter int RST_CNT_BITS = 16,
	parameter int ACT_CNT_BITS = 7,
	parameter int GP0_COUNT    = 16,
	parameter int GP1_COUNT    = 5
) (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  soc_bus_pkg::bus_op_e bus_op_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] bus_wdata_i,
	input  logic [soc_bus_pkg::SEL_W-1:0] bus_sel_i,
	output logic [soc_bus_pkg::DATA_W-1:0] bus_rdata_o,
	output logic bus_rdy_o,
	input  logic [GP0_COUNT-1:0] gp0_i,
	output logic [GP0_COUNT-1:0] gp0_o,
	input  logic [GP1_COUNT-1:0] gp1_i,
	output logic sys_rst_o,
	output logic irq_o,
	output logic activity_o
);
	import soc_bus_pkg::*;
	import soc_devmap_pkg::*;

	bus_op_e slv_op;
	logic [ADDR_W-1:0] slv_addr;
	logic [DATA_W-1:0] slv_wdata;
	logic [SEL_W-1:0] slv_sel;
	logic [SLAVE_COUNT-1:0] slv_stb;
	logic [DATA_W-1:0] dt_rdata;
	logic [DATA_W-1:0] gp0_rdata;
	logic [DATA_W-1:0] gp1_rdata;
	logic sw_rst0;
	logic sw_rst1;
	logic gp0_irq;
	logic gp1_irq;

	reset_seq #(.RST_CNT_BITS(RST_CNT_BITS)) i_reset_seq (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.sw_rst0_i(sw_rst0), .sw_rst1_i(sw_rst1), .sys_rst_o(sys_rst_o)
	);

	bus_decoder i_bus_decoder (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_o),
		.bus_op_i(bus_op_i), .bus_addr_i(bus_addr_i),
		.bus_wdata_i(bus_wdata_i), .bus_sel_i(bus_sel_i),
		.bus_rdata_o(bus_rdata_o), .bus_rdy_o(bus_rdy_o),
		.slv_op_o(slv_op), .slv_addr_o(slv_addr), .slv_wdata_o(slv_wdata),
		.slv_sel_o(slv_sel), .slv_stb_o(slv_stb),
		.dt_rdata_i(dt_rdata), .gp0_rdata_i(gp0_rdata), .gp1_rdata_i(gp1_rdata)
	);

	dev_table i_dev_table (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_o), .stb_i(slv_stb[SL_DEVTBL]),
		.op_i(slv_op), .addr_i(slv_addr[DT_ADDR_W-1:0]), .wdata_i(slv_wdata),
		.rdata_o(dt_rdata), .sw_rst0_o(sw_rst0), .sw_rst1_o(sw_rst1)
	);

	// Switches and LEDs
	gpio_port #(.IO_COUNT(GP0_COUNT)) i_gpio_gp0 (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_o), .stb_i(slv_stb[SL_GP0]),
		.op_i(slv_op), .addr_i(slv_addr[1:0]), .wdata_i(slv_wdata), .sel_i(slv_sel),
		.rdata_o(gp0_rdata), .pins_i(gp0_i), .pins_o(gp0_o), .irq_o(gp0_irq)
	);

	// Buttons, input only
	gpio_port #(.IO_COUNT(GP1_COUNT)) i_gpio_gp1 (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_o), .stb_i(slv_stb[SL_GP1]),
		.op_i(slv_op), .addr_i(slv_addr[1:0]), .wdata_i(slv_wdata), .sel_i(slv_sel),
		.rdata_o(gp1_rdata), .pins_i(gp1_i), .pins_o(), .irq_o(gp1_irq)
	);

	activity_led #(.ACT_CNT_BITS(ACT_CNT_BITS)) i_activity_led (
		.clk_2x_w(clk_2x_w), .sys_rst_i(sys_rst_o),
		.trig_i(bus_rdy_o), .activity_o(activity_o)
	);

	assign irq_o = gp0_irq | gp1_irq;

endmodule

// File: verification/tb_soc_ctrl_top.sv
//############################
// Random-stimulus testbench for the system controller,
// checked against a register and activity model
//############################
`timescale 1ns/1ps

module tb_soc_ctrl_top;
	import soc_bus_pkg::*;

	localparam int RST_BITS = 4;
	localparam int ACT_BITS = 4;
	localparam int ACT_HOLD = 2 ** ACT_BITS - 1;
	localparam int EXP_LATENCY = 2;
	localparam int RDY_LIMIT = 16;
	// Rough cycle budget per test, in run order
	localparam int TEST_CYCLES = 30 + 200 + 270 + 80 + 90 + 140;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk_2x_w;
	logic rst_p;
	bus_op_e bus_op;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata;
	logic [SEL_W-1:0] bus_sel;
	logic [DATA_W-1:0] bus_rdata;
	logic bus_rdy;
	logic [15:0] gp0_in;
	logic [15:0] gp0_out;
	logic [4:0] gp1_in;
	logic sys_rst;
	logic irq;
	logic activity;
	integer seed;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err_start = 0;
	int act_model_cnt = 0;
	int act_seen_cnt = 0;

	soc_ctrl_top #(
		.RST_CNT_BITS(RST_BITS), .ACT_CNT_BITS(ACT_BITS), .GP0_COUNT(16), .GP1_COUNT(5)
	) i_soc_ctrl_top (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.bus_op_i(bus_op), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
		.bus_sel_i(bus_sel), .bus_rdata_o(bus_rdata), .bus_rdy_o(bus_rdy),
		.gp0_i(gp0_in), .gp0_o(gp0_out), .gp1_i(gp1_in),
		.sys_rst_o(sys_rst), .irq_o(irq), .activity_o(activity)
	);

	always #2 clk_2x_w = ~clk_2x_w;

	always @(posedge clk_2x_w) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles", cycle);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - test_err_start);
		test_err_start = errors;
	endtask

	// Word layout of the device table: id with interrupt flag, then map size
	function automatic logic [DATA_W-1:0] dt_expect(input logic [3:0] word);
		case (word)
			4'd0: return 32'd7;
			4'd1: return 32'd16;
			4'd2, 4'd4: return 32'h8000_0006;
			4'd3, 4'd5: return 32'd4;
			4'd15: return 32'd2;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [15:0] merge16(input logic [15:0] old,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel);
		logic [15:0] mask;
		mask = {{8{sel[1]}}, {8{sel[0]}}};
		return (old & ~mask) | (wdata[15:0] & mask);
	endfunction

	// Ready is seen 2 edges after the edge that samples the request
	task automatic bus_xfer(input bus_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel, input bit keep,
			output logic [DATA_W-1:0] rdata);
		int lat;
		@(posedge clk_2x_w);
		bus_op <= op;
		bus_addr <= addr;
		bus_wdata <= wdata;
		bus_sel <= sel;
		lat = 0;
		@(negedge clk_2x_w);
		while (!bus_rdy && lat < RDY_LIMIT) begin
			@(negedge clk_2x_w);
			lat++;
		end
		rdata = bus_rdata;
		if (!bus_rdy) begin
			errors++;
			$display("Bus request to word %0d got no ready within %0d cycles", addr, RDY_LIMIT);
		end else begin
			check_value("bus_rdy_o latency", lat, EXP_LATENCY);
		end
		if (!keep) begin
			@(posedge clk_2x_w);
			bus_op <= OP_NOP;
			@(negedge clk_2x_w);
		end
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
		bus_xfer(OP_READ, addr, '0, '0, 1'b0, rdata);
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
			input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] rdata;
		bus_xfer(OP_WRITE, addr, wdata, sel, 1'b0, rdata);
		check_value("bus_rdata_o on write", rdata, 32'd0);
	endtask

	task automatic wait_release(output int n);
		n = 0;
		while (sys_rst && n < 64) begin
			@(negedge clk_2x_w);
			n++;
		end
	endtask

	// Pulse one cycle after a ready when idle, then ignore readies for ACT_HOLD cycles
	task automatic watch_activity();
		logic prev_rdy;
		logic prev_rst;
		logic exp_act;
		int hold;
		prev_rdy = 1'b0;
		prev_rst = 1'b1;
		hold = 0;
		forever begin
			@(negedge clk_2x_w);
			if (cycle >= 2) begin
				exp_act = prev_rdy && !prev_rst && (hold == 0);
				check_value("activity_o", 32'(activity), 32'(exp_act));
				if (prev_rst)
					hold = 0;
				else if (exp_act)
					hold = ACT_HOLD;
				else if (hold != 0)
					hold--;
				act_model_cnt += int'(exp_act);
				act_seen_cnt += int'(activity);
			end
			prev_rdy = bus_rdy;
			prev_rst = sys_rst;
		end
	endtask

	initial begin
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] wd;
		logic [SEL_W-1:0] sel;
		logic [3:0] w;
		logic [31:0] r;
		logic [15:0] gp0_model;
		logic [15:0] old0;
		logic [4:0] old1;
		int n;
		int base_seen;
		int base_model;
		clk_2x_w = 1'b0;
		rst_p = 1'b1;
		bus_op = OP_NOP;
		bus_addr = '0;
		bus_wdata = '0;
		bus_sel = '0;
		gp0_in = '0;
		gp1_in = '0;
		seed = 32'he38d8973;
		gp0_model = '0;
		fork
			watch_activity();
		join_none

		// A request held through reset must never complete
		repeat (10) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		bus_op <= OP_READ;
		bus_addr <= 30'd15;
		@(negedge clk_2x_w);
		n = 0;
		while (sys_rst && n < 64) begin
			check_value("bus_rdy_o", 32'(bus_rdy), 32'd0);
			check_value("irq_o", 32'(irq), 32'd0);
			check_value("gp0_o", 32'(gp0_out), 32'd0);
			@(posedge clk_2x_w);
			if (n == 8)
				bus_op <= OP_NOP;
			@(negedge clk_2x_w);
			n++;
		end
		check_value("sys_rst_o release cycle", n, 2 ** RST_BITS - 1);
		end_test("reset_release");

		for (int i = 0; i < 50; i++) begin
			w = 4'($random(seed));
			bus_read({26'd0, w}, rd);
			check_value("device table word", rd, dt_expect(w));
		end
		end_test("device_table");

		for (int i = 0; i < 20; i++) begin
			wd = $random(seed);
			sel = 4'($random(seed));
			bus_write(30'd17, wd, sel);
			gp0_model = merge16(gp0_model, wd, sel);
			check_value("gp0_o", 32'(gp0_out), 32'(gp0_model));
		end
		for (int i = 0; i < 10; i++) begin
			@(posedge clk_2x_w);
			gp0_in <= 16'($random(seed));
			gp1_in <= 5'($random(seed));
			repeat (3) @(posedge clk_2x_w);
			bus_read(30'd16, rd);
			check_value("gp0 input word", rd, 32'(gp0_in));
			bus_read(30'd20, rd);
			check_value("gp1 input word", rd, 32'(gp1_in));
		end
		bus_write(30'd18, '1, 4'hF);
		bus_write(30'd22, '1, 4'hF);
		bus_read(30'd18, rd);
		check_value("gp0 change flags", rd, 32'd0);
		bus_read(30'd22, rd);
		check_value("gp1 change flags", rd, 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		old0 = gp0_in;
		old1 = gp1_in;
		@(posedge clk_2x_w);
		gp0_in <= gp0_in ^ (16'($random(seed)) | 16'h1);
		repeat (5) @(negedge clk_2x_w);
		// Only the switch port has flags up here
		check_value("irq_o", 32'(irq), 32'd1);
		@(posedge clk_2x_w);
		gp1_in <= gp1_in ^ (5'($random(seed)) | 5'h1);
		repeat (5) @(posedge clk_2x_w);
		bus_read(30'd18, rd);
		check_value("gp0 change flags", rd, 32'(old0 ^ gp0_in));
		bus_read(30'd22, rd);
		check_value("gp1 change flags", rd, 32'(old1 ^ gp1_in));
		check_value("irq_o", 32'(irq), 32'd1);
		bus_write(30'd18, 32'(old0 ^ gp0_in), 4'hF);
		// The button port alone still holds the interrupt
		check_value("irq_o", 32'(irq), 32'd1);
		bus_write(30'd22, 32'(old1 ^ gp1_in), 4'hF);
		bus_read(30'd18, rd);
		check_value("gp0 change flags", rd, 32'd0);
		bus_read(30'd22, rd);
		check_value("gp1 change flags", rd, 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		end_test("gpio_ports");

		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			bus_read(30'd24 + 30'(r % 32'h3FFF_FFE8), rd);
			check_value("default slave data", rd, 32'd0);
		end
		end_test("default_slave");

		base_seen = act_seen_cnt;
		base_model = act_model_cnt;
		for (int i = 0; i < 20; i++)
			bus_xfer(OP_READ, 30'(16 + (i % 8)), '0, 4'hF, i != 19, rd);
		repeat (20) @(negedge clk_2x_w);
		check_value("activity_o pulse count", act_seen_cnt - base_seen,
			act_model_cnt - base_model);
		check_value("activity_o burst pulses", 32'((act_model_cnt - base_model) >= 2), 32'd1);
		end_test("activity");

		// Cold reset first, then warm
		for (int i = 0; i < 2; i++) begin
			bus_write(30'd17, 32'h0000_5AA5, 4'h3);
			check_value("gp0_o", 32'(gp0_out), 32'h0000_5AA5);
			bus_write(30'd15, (i == 0) ? 32'd3 : 32'd2, 4'hF);
			check_value("sys_rst_o", 32'(sys_rst), 32'd1);
			wait_release(n);
			check_value("sys_rst_o high cycles", n, 2 ** RST_BITS - 1);
			check_value("gp0_o", 32'(gp0_out), 32'd0);
		end
		bus_write(30'd15, 32'd1, 4'hF);
		repeat (40) begin
			check_value("sys_rst_o", 32'(sys_rst), 32'd1);
			@(negedge clk_2x_w);
		end
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		@(negedge clk_2x_w);
		wait_release(n);
		check_value("sys_rst_o release cycle", n, 2 ** RST_BITS - 1);
		bus_read(30'd15, rd);
		check_value("device table word", rd, dt_expect(4'd15));
		end_test("software_reset");

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: project.f
src/soc_bus_pkg.sv
src/soc_devmap_pkg.sv
src/reset_seq.sv
src/bus_decoder.sv
src/dev_table.sv
src/gpio_port.sv
src/activity_led.sv
src/soc_ctrl_top.sv
verification/tb_soc_ctrl_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_soc_ctrl_top \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF "Regression passed"; then
	exit 0
fi
echo "Pass message not found"
exit 1
